// File: test/dbus_stimulus.txt
# op(L/S) kind(LB LBU LH LHU LW SB SH SW) addr wdata gpio_in exp_data exp_err
# numbers in hex, exp_data is zero for stores and errors
L LW  00000040 00000000 00000000 00000000 0
S SW  00000040 deadbeef 00000000 00000000 0
L LW  00000040 00000000 00000000 deadbeef 0
S SW  00000044 11223344 00000000 00000000 0
S SB  00000044 000000aa 00000000 00000000 0
S SB  00000045 000000bb 00000000 00000000 0
S SB  00000046 000000cc 00000000 00000000 0
S SB  00000047 000000dd 00000000 00000000 0
L LW  00000044 00000000 00000000 ddccbbaa 0
S SH  00000048 0000a5a5 00000000 00000000 0
S SH  0000004a 00005a5a 00000000 00000000 0
L LW  00000048 00000000 00000000 5a5aa5a5 0
L LB  00000044 00000000 00000000 ffffffaa 0
L LBU 00000045 00000000 00000000 000000bb 0
L LH  00000048 00000000 00000000 ffffa5a5 0
L LHU 0000004a 00000000 00000000 00005a5a 0
S SW  0000004c 7f01ff80 00000000 00000000 0
L LB  0000004e 00000000 00000000 00000001 0
L LH  0000004e 00000000 00000000 00007f01 0
L LHU 0000004c 00000000 00000000 0000ff80 0
S SW  80000000 0000a5c3 00000000 00000000 0
S SW  80000004 000000ff 00000000 00000000 0
L LW  80000000 00000000 00000000 0000a5c3 0
L LW  80000004 00000000 00000000 000000ff 0
L LW  80000008 00000000 13572468 13572468 0
L LW  8000000c 00000000 13572468 00000000 0
S SW  00000400 ffffffff 13572468 00000000 1
L LW  00000000 00000000 13572468 00000000 0
L LW  40000000 00000000 13572468 00000000 1
L LB  00001000 00000000 13572468 00000000 1
S SW  00000080 01020304 13572468 00000000 0
S SW  00000084 05060708 13572468 00000000 0
L LW  00000080 00000000 13572468 01020304 0
L LW  00000084 00000000 13572468 05060708 0
S SB  00000081 000000ee 13572468 00000000 0
L LW  00000080 00000000 13572468 0102ee04 0

// File: sources.f
+incdir+common
common/dbus_pkg.sv
logic/dbus_req_fifo.sv
dbus/dbus_interconnect.sv
dbus/dbus_load_align.sv
logic/dbus_data_mem.sv
logic/dbus_gpio_regs.sv
dbus/dbus_subsys.sv
test/tb_dbus_subsys.sv

// File: Bender.yml
package:
  name: dbus_subsys

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/dbus_pkg.sv
      - logic/dbus_req_fifo.sv
      - dbus/dbus_interconnect.sv
      - dbus/dbus_load_align.sv
      - logic/dbus_data_mem.sv
      - logic/dbus_gpio_regs.sv
      - dbus/dbus_subsys.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_dbus_subsys.sv

// File: test/tb_dbus_subsys.sv
// ------------------------------
// Testbench for dbus_subsys
//   reads requests and expected
//   responses from a text file
//   credit-paced request driver
//   in-order response checker
// ------------------------------

`timescale 1ns/1ns
`include "dbus_params.svh"

module tb_dbus_subsys;

    localparam int          BURST_LEN     = 6;   // Last requests go out back to back
    localparam logic [31:0] GPIO_OUT_ADDR = 32'h8000_0000;
    localparam logic [31:0] GPIO_DIR_ADDR = 32'h8000_0004;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              req_valid_i;
    logic [31:0]       req_addr_i;
    logic [31:0]       req_wdata_i;
    dbus_pkg::ld_ops_e req_ld_ops_i;
    dbus_pkg::st_ops_e req_st_ops_i;
    logic              credit_o;
    logic              rsp_valid_o;
    logic [31:0]       rsp_data_o;
    logic              rsp_err_o;
    logic [31:0]       gpio_in_i;
    logic [31:0]       gpio_out_o;
    logic [31:0]       gpio_dir_o;

    // One entry per request line of the file
    dbus_pkg::ld_ops_e ld_q[$];
    dbus_pkg::st_ops_e st_q[$];
    logic [31:0]       addr_q[$];
    logic [31:0]       wdata_q[$];
    logic [31:0]       gin_q[$];
    logic [31:0]       edata_q[$];
    logic              eerr_q[$];
    int                line_q[$];
    int                exp_idx_q[$];   // Requests waiting for a response

    integer      seed = 32'h68c5_ee45;
    int          n_req;
    int          errors;
    int          credits;
    int          rx_count;
    int          cycles;
    int          cycle_limit = 50;
    logic [31:0] gpio_out_exp;
    logic [31:0] gpio_dir_exp;

    dbus_subsys dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_ld_ops_i (req_ld_ops_i),
        .req_st_ops_i (req_st_ops_i),
        .credit_o     (credit_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_data_o   (rsp_data_o),
        .rsp_err_o    (rsp_err_o),
        .gpio_in_i    (gpio_in_i),
        .gpio_out_o   (gpio_out_o),
        .gpio_dir_o   (gpio_dir_o)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic read_stimulus(output bit ok);
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [7:0]  op_c;
        logic [23:0] kind_s;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] gin;
        logic [31:0] edata;
        logic [31:0] eerr;
        dbus_pkg::ld_ops_e ld;
        dbus_pkg::st_ops_e st;
        ok      = 1'b1;
        line_no = 0;
        fd = $fopen("test/dbus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("stimulus file test/dbus_stimulus.txt could not be opened");
            ok = 1'b0;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%s %s %h %h %h %h %h", op_c, kind_s, addr, wdata, gin,
                        edata, eerr);
            ld = dbus_pkg::LD_OPS_NONE;
            st = dbus_pkg::ST_OPS_NONE;
            case (kind_s)
                "LB":    ld = dbus_pkg::LD_OPS_LB;
                "LBU":   ld = dbus_pkg::LD_OPS_LBU;
                "LH":    ld = dbus_pkg::LD_OPS_LH;
                "LHU":   ld = dbus_pkg::LD_OPS_LHU;
                "LW":    ld = dbus_pkg::LD_OPS_LW;
                "SB":    st = dbus_pkg::ST_OPS_SB;
                "SH":    st = dbus_pkg::ST_OPS_SH;
                "SW":    st = dbus_pkg::ST_OPS_SW;
                default: ;
            endcase
            // Letter and kind must agree
            if (n != 7 || !((op_c == "L" && ld != dbus_pkg::LD_OPS_NONE) ||
                            (op_c == "S" && st != dbus_pkg::ST_OPS_NONE))) begin
                $display("stimulus line %0d is malformed", line_no);
                ok = 1'b0;
                continue;
            end
            ld_q.push_back(ld);
            st_q.push_back(st);
            addr_q.push_back(addr);
            wdata_q.push_back(wdata);
            gin_q.push_back(gin);
            edata_q.push_back(edata);
            eerr_q.push_back(eerr[0]);
            line_q.push_back(line_no);
        end
        $fclose(fd);
    endtask

    // One clock edge with credit bookkeeping and the request dropped
    task automatic step_cycle();
        @(posedge clk);
        if (credit_o) credits++;
        if (req_valid_i) credits--;
        req_valid_i <= 1'b0;
    endtask

    task automatic run_requests();
        int idx;
        int gap;
        idx = 0;
        while (idx < n_req) begin
            step_cycle();
            if (gin_q[idx] !== gpio_in_i) begin
                // Change the pins only with the pipe drained and let the sync settle
                while (credits != `DBUS_FIFO_DEPTH) step_cycle();
                gpio_in_i <= gin_q[idx];
                repeat (4) step_cycle();
            end
            gap = (idx >= n_req - BURST_LEN) ? 0 : $unsigned($random(seed)) % 4;
            repeat (gap) step_cycle();
            while (credits == 0) step_cycle();
            req_valid_i  <= 1'b1;
            req_addr_i   <= addr_q[idx];
            req_wdata_i  <= wdata_q[idx];
            req_ld_ops_i <= ld_q[idx];
            req_st_ops_i <= st_q[idx];
            exp_idx_q.push_back(idx);
            idx++;
        end
        while (rx_count < n_req) step_cycle();
        repeat (2) step_cycle();
    endtask

    always @(negedge clk) begin : response_check
        int k;
        if (rst_n_i && rsp_valid_o) begin
            if (exp_idx_q.size() == 0) begin
                errors++;
                $display("response at %0t arrived with no request outstanding", $time);
            end else begin
                k = exp_idx_q.pop_front();
                check_value($sformatf("rsp_data_o (line %0d)", line_q[k]), rsp_data_o,
                            edata_q[k]);
                check_value($sformatf("rsp_err_o (line %0d)", line_q[k]), rsp_err_o,
                            eerr_q[k]);
                if (ld_q[k] == dbus_pkg::LD_OPS_LW && addr_q[k] == GPIO_OUT_ADDR)
                    gpio_out_exp = edata_q[k];
                if (ld_q[k] == dbus_pkg::LD_OPS_LW && addr_q[k] == GPIO_DIR_ADDR)
                    gpio_dir_exp = edata_q[k];
                rx_count++;
            end
        end
    end

    // Run limit from the number of requests
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, responses stopped arriving", cycles);
        $display("%0d of %0d responses, %0d errors", rx_count, n_req, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        bit ok;
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        req_ld_ops_i = dbus_pkg::LD_OPS_NONE;
        req_st_ops_i = dbus_pkg::ST_OPS_NONE;
        gpio_in_i    = '0;
        errors       = 0;
        rx_count     = 0;
        credits      = `DBUS_FIFO_DEPTH;
        gpio_out_exp = '0;
        gpio_dir_exp = '0;
        read_stimulus(ok);
        n_req       = ld_q.size();
        cycle_limit = n_req * 8 + 50;
        if (!ok || n_req == 0) begin
            errors++;
            $display("no usable requests in the stimulus file");
        end else begin
            repeat (4) @(posedge clk);
            rst_n_i <= 1'b1;
            run_requests();
            check_value("credits", credits, `DBUS_FIFO_DEPTH);
            check_value("gpio_out_o", gpio_out_o, gpio_out_exp);
            check_value("gpio_dir_o", gpio_dir_o, gpio_dir_exp);
        end
        $display("%0d of %0d responses, %0d errors", rx_count, n_req, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_dbus_subsys

// File: dbus/dbus_subsys.sv
// ------------------------------
// Data bus subsystem top
//   request buffer, interconnect
//   data memory, GPIO registers
//   load aligner
// ------------------------------

`timescale 1ns/1ns
`include "dbus_params.svh"

module dbus_subsys (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          req_valid_i,
    input  logic [`DBUS_ADDR_WIDTH-1:0]   req_addr_i,
    input  logic [`DBUS_DATA_WIDTH-1:0]   req_wdata_i,
    input  dbus_pkg::ld_ops_e             req_ld_ops_i,
    input  dbus_pkg::st_ops_e             req_st_ops_i,
    output logic                          credit_o,
    output logic                          rsp_valid_o,
    output logic [`DBUS_DATA_WIDTH-1:0]   rsp_data_o,
    output logic                          rsp_err_o,
    input  logic [31:0]                   gpio_in_i,
    output logic [31:0]                   gpio_out_o,
    output logic [31:0]                   gpio_dir_o
);

    logic                        head_valid;
    logic [`DBUS_ADDR_WIDTH-1:0] head_addr;
    logic [`DBUS_DATA_WIDTH-1:0] head_wdata;
    dbus_pkg::ld_ops_e           head_ld_ops;
    dbus_pkg::st_ops_e           head_st_ops;

    logic [`DBUS_ADDR_WIDTH-1:0] bus_addr;
    logic [`DBUS_DATA_WIDTH-1:0] bus_wdata;
    logic [3:0]                  bus_be;
    logic                        bus_wen;
    logic                        dmem_sel;
    logic                        gpio_sel;
    logic [`DBUS_DATA_WIDTH-1:0] dmem_rdata;
    logic [`DBUS_DATA_WIDTH-1:0] gpio_rdata;

    logic                        rsp_pending;
    dbus_pkg::ld_ops_e           rsp_ld_ops;
    logic [1:0]                  rsp_byte_off;
    logic                        rsp_err;
    logic [`DBUS_DATA_WIDTH-1:0] rsp_rdata;

    dbus_req_fifo u_req_fifo (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_addr_i    (req_addr_i),
        .req_wdata_i   (req_wdata_i),
        .req_ld_ops_i  (req_ld_ops_i),
        .req_st_ops_i  (req_st_ops_i),
        .credit_o      (credit_o),
        .head_valid_o  (head_valid),
        .head_addr_o   (head_addr),
        .head_wdata_o  (head_wdata),
        .head_ld_ops_o (head_ld_ops),
        .head_st_ops_o (head_st_ops)
    );

    dbus_interconnect u_interconnect (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .head_valid_i   (head_valid),
        .head_addr_i    (head_addr),
        .head_wdata_i   (head_wdata),
        .head_ld_ops_i  (head_ld_ops),
        .head_st_ops_i  (head_st_ops),
        .dmem_rdata_i   (dmem_rdata),
        .gpio_rdata_i   (gpio_rdata),
        .bus_addr_o     (bus_addr),
        .bus_wdata_o    (bus_wdata),
        .bus_be_o       (bus_be),
        .bus_wen_o      (bus_wen),
        .dmem_sel_o     (dmem_sel),
        .gpio_sel_o     (gpio_sel),
        .rsp_pending_o  (rsp_pending),
        .rsp_ld_ops_o   (rsp_ld_ops),
        .rsp_byte_off_o (rsp_byte_off),
        .rsp_err_o      (rsp_err),
        .rsp_rdata_o    (rsp_rdata)
    );

    dbus_data_mem u_data_mem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .sel_i   (dmem_sel),
        .wen_i   (bus_wen),
        .addr_i  (bus_addr),
        .wdata_i (bus_wdata),
        .be_i    (bus_be),
        .rdata_o (dmem_rdata)
    );

    dbus_gpio_regs u_gpio_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .sel_i      (gpio_sel),
        .wen_i      (bus_wen),
        .addr_i     (bus_addr),
        .wdata_i    (bus_wdata),
        .be_i       (bus_be),
        .gpio_in_i  (gpio_in_i),
        .rdata_o    (gpio_rdata),
        .gpio_out_o (gpio_out_o),
        .gpio_dir_o (gpio_dir_o)
    );

    dbus_load_align u_load_align (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rsp_pending_i  (rsp_pending),
        .rsp_ld_ops_i   (rsp_ld_ops),
        .rsp_byte_off_i (rsp_byte_off),
        .rsp_err_i      (rsp_err),
        .rsp_rdata_i    (rsp_rdata),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_data_o     (rsp_data_o),
        .rsp_err_o      (rsp_err_o)
    );

endmodule : dbus_subsys

// File: logic/dbus_gpio_regs.sv
// ------------------------------
// GPIO register target
//   output and direction regs
//   synchronized input port
// ------------------------------

`timescale 1ns/1ns
`include "dbus_params.svh"

module dbus_gpio_regs (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          sel_i,
    input  logic                          wen_i,
    input  logic [`DBUS_ADDR_WIDTH-1:0]   addr_i,
    input  logic [`DBUS_DATA_WIDTH-1:0]   wdata_i,
    input  logic [3:0]                    be_i,
    input  logic [31:0]                   gpio_in_i,
    output logic [`DBUS_DATA_WIDTH-1:0]   rdata_o,
    output logic [31:0]                   gpio_out_o,
    output logic [31:0]                   gpio_dir_o
);

    dbus_pkg::dbus_addr_u addr_u;
    logic [31:0]          in_meta;
    logic [31:0]          in_sync;

    assign addr_u = addr_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpio_out_o <= '0;
            gpio_dir_o <= '0;   // All pins inputs
            in_meta    <= '0;
            in_sync    <= '0;
            rdata_o    <= '0;
        end else begin
            in_meta <= gpio_in_i;
            in_sync <= in_meta;
            if (sel_i) begin
                case (addr_u.peri.reg_idx)
                    `GPIO_REG_OUT: rdata_o <= gpio_out_o;
                    `GPIO_REG_DIR: rdata_o <= gpio_dir_o;
                    `GPIO_REG_IN:  rdata_o <= in_sync;
                    default:       rdata_o <= '0;
                endcase
            end
            for (int b = 0; b < 4; b++) begin
                if (sel_i && wen_i && be_i[b]) begin
                    if (addr_u.peri.reg_idx == `GPIO_REG_OUT) gpio_out_o[b*8 +: 8] <= wdata_i[b*8 +: 8];
                    if (addr_u.peri.reg_idx == `GPIO_REG_DIR) gpio_dir_o[b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

endmodule : dbus_gpio_regs

// File: logic/dbus_data_mem.sv
// ------------------------------
// Data memory target
//   256 x 32 word array
//   byte-enabled writes
//   registered read on select
// ------------------------------

`timescale 1ns/1ns
`include "dbus_params.svh"

module dbus_data_mem (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          sel_i,
    input  logic                          wen_i,
    input  logic [`DBUS_ADDR_WIDTH-1:0]   addr_i,
    input  logic [`DBUS_DATA_WIDTH-1:0]   wdata_i,
    input  logic [3:0]                    be_i,
    output logic [`DBUS_DATA_WIDTH-1:0]   rdata_o
);

    logic [`DBUS_DATA_WIDTH-1:0] mem [`DMEM_WORDS];
    dbus_pkg::dbus_addr_u        addr_u;

    assign addr_u = addr_i;

    // Contents cleared so reads are predictable
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < `DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
            rdata_o <= '0;
        end else if (sel_i) begin
            rdata_o <= mem[addr_u.mem.word_idx];
            if (wen_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b]) mem[addr_u.mem.word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

endmodule : dbus_data_mem

// File: dbus/dbus_load_align.sv
// ------------------------------
// Load alignment
//   byte and half-word select
//   sign or zero extension
//   registered core response
// ------------------------------

`timescale 1ns/1ns
`include "dbus_params.svh"

module dbus_load_align (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          rsp_pending_i,
    input  dbus_pkg::ld_ops_e             rsp_ld_ops_i,
    input  logic [1:0]                    rsp_byte_off_i,
    input  logic                          rsp_err_i,
    input  logic [`DBUS_DATA_WIDTH-1:0]   rsp_rdata_i,
    output logic                          rsp_valid_o,
    output logic [`DBUS_DATA_WIDTH-1:0]   rsp_data_o,
    output logic                          rsp_err_o
);

    logic [7:0]                  ld_byte;
    logic [15:0]                 ld_half;
    logic [`DBUS_DATA_WIDTH-1:0] ld_data;

    assign ld_byte = rsp_rdata_i[{rsp_byte_off_i, 3'b000} +: 8];
    assign ld_half = rsp_byte_off_i[1] ? rsp_rdata_i[31:16] : rsp_rdata_i[15:0];

    always_comb begin
        case (rsp_ld_ops_i)
            dbus_pkg::LD_OPS_LB:  ld_data = {{(`DBUS_DATA_WIDTH-8){ld_byte[7]}}, ld_byte};
            dbus_pkg::LD_OPS_LBU: ld_data = {{(`DBUS_DATA_WIDTH-8){1'b0}}, ld_byte};
            dbus_pkg::LD_OPS_LH:  ld_data = {{(`DBUS_DATA_WIDTH-16){ld_half[15]}}, ld_half};
            dbus_pkg::LD_OPS_LHU: ld_data = {{(`DBUS_DATA_WIDTH-16){1'b0}}, ld_half};
            dbus_pkg::LD_OPS_LW:  ld_data = rsp_rdata_i;
            default:              ld_data = '0;   // Stores return zero
        endcase
        if (rsp_err_i) ld_data = '0;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            rsp_err_o   <= 1'b0;
        end else begin
            rsp_valid_o <= rsp_pending_i;
            rsp_err_o   <= rsp_pending_i & rsp_err_i;
        end
    end

    always_ff @(posedge clk) begin
        rsp_data_o <= ld_data;
    end

    // Core never issues a misaligned half-word load
    a_half_aligned : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (rsp_pending_i && (rsp_ld_ops_i inside {dbus_pkg::LD_OPS_LH, dbus_pkg::LD_OPS_LHU}))
            |-> !rsp_byte_off_i[0]
    );

endmodule : dbus_load_align

// File: dbus/dbus_interconnect.sv
// ------------------------------
// Data bus interconnect
//   address decode, DMEM first
//   store lane steering and BE
//   registered response info
//   read data return mux
// ------------------------------

`timescale 1ns/1ns
`include "dbus_params.svh"

module dbus_interconnect (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          head_valid_i,
    input  logic [`DBUS_ADDR_WIDTH-1:0]   head_addr_i,
    input  logic [`DBUS_DATA_WIDTH-1:0]   head_wdata_i,
    input  dbus_pkg::ld_ops_e             head_ld_ops_i,
    input  dbus_pkg::st_ops_e             head_st_ops_i,
    input  logic [`DBUS_DATA_WIDTH-1:0]   dmem_rdata_i,
    input  logic [`DBUS_DATA_WIDTH-1:0]   gpio_rdata_i,
    output logic [`DBUS_ADDR_WIDTH-1:0]   bus_addr_o,
    output logic [`DBUS_DATA_WIDTH-1:0]   bus_wdata_o,
    output logic [3:0]                    bus_be_o,
    output logic                          bus_wen_o,
    output logic                          dmem_sel_o,
    output logic                          gpio_sel_o,
    output logic                          rsp_pending_o,
    output dbus_pkg::ld_ops_e             rsp_ld_ops_o,
    output logic [1:0]                    rsp_byte_off_o,
    output logic                          rsp_err_o,
    output logic [`DBUS_DATA_WIDTH-1:0]   rsp_rdata_o
);

    dbus_pkg::dbus_addr_u addr_u;
    logic                 ld_req;
    logic                 st_req;
    logic                 dbus_req;
    logic                 dmem_match;
    logic                 gpio_match;
    logic                 dmem_sel_q;
    logic                 gpio_sel_q;

    assign addr_u   = head_addr_i;
    assign ld_req   = (head_ld_ops_i != dbus_pkg::LD_OPS_NONE);
    assign st_req   = (head_st_ops_i != dbus_pkg::ST_OPS_NONE);
    assign dbus_req = head_valid_i & (ld_req | st_req);

    assign dmem_match = (addr_u.mem.region == `DMEM_REGION_MATCH);
    assign gpio_match = (addr_u.peri.sel == `GPIO_SEL_MATCH);

    // DMEM has priority over GPIO
    always_comb begin
        dmem_sel_o = 1'b0;
        gpio_sel_o = 1'b0;
        if (dmem_match & dbus_req) begin
            dmem_sel_o = 1'b1;
        end else if (gpio_match & dbus_req) begin
            gpio_sel_o = 1'b1;
        end
    end

    // Steer store data into its byte lanes
    always_comb begin
        bus_wdata_o = '0;
        bus_be_o    = 4'b0000;
        case (head_st_ops_i)
            dbus_pkg::ST_OPS_SB: begin
                bus_wdata_o[{addr_u.mem.byte_off, 3'b000} +: 8] = head_wdata_i[7:0];
                bus_be_o = 4'b0001 << addr_u.mem.byte_off;
            end
            dbus_pkg::ST_OPS_SH: begin
                if (addr_u.mem.byte_off[1]) begin
                    bus_wdata_o[31:16] = head_wdata_i[15:0];
                    bus_be_o           = 4'b1100;
                end else begin
                    bus_wdata_o[15:0] = head_wdata_i[15:0];
                    bus_be_o          = 4'b0011;
                end
            end
            dbus_pkg::ST_OPS_SW: begin
                bus_wdata_o = head_wdata_i;
                bus_be_o    = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    assign bus_addr_o = head_addr_i;
    assign bus_wen_o  = head_valid_i & st_req;   // Targets qualify with their select

    // Remember the request for the response cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_pending_o  <= 1'b0;
            rsp_ld_ops_o   <= dbus_pkg::LD_OPS_NONE;
            rsp_byte_off_o <= 2'b00;
            rsp_err_o      <= 1'b0;
            dmem_sel_q     <= 1'b0;
            gpio_sel_q     <= 1'b0;
        end else begin
            rsp_pending_o  <= head_valid_i;
            rsp_ld_ops_o   <= head_valid_i ? head_ld_ops_i : dbus_pkg::LD_OPS_NONE;
            rsp_byte_off_o <= addr_u.mem.byte_off;
            rsp_err_o      <= dbus_req & ~(dmem_sel_o | gpio_sel_o);   // Unmapped
            dmem_sel_q     <= dmem_sel_o;
            gpio_sel_q     <= gpio_sel_o;
        end
    end

    assign rsp_rdata_o = dmem_sel_q ? dmem_rdata_i
                       : gpio_sel_q ? gpio_rdata_i
                       : '0;

    // A valid head carries exactly one of a load or a store
    a_one_op : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        head_valid_i |-> (ld_req ^ st_req)
    );

endmodule : dbus_interconnect

// File: logic/dbus_req_fifo.sv
// ------------------------------
// Core-side request buffer
//   circular FIFO of requests
//   one credit pulse per pop
// ------------------------------

`timescale 1ns/1ns
`include "dbus_params.svh"

module dbus_req_fifo (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         req_valid_i,
    input  logic [`DBUS_ADDR_WIDTH-1:0]  req_addr_i,
    input  logic [`DBUS_DATA_WIDTH-1:0]  req_wdata_i,
    input  dbus_pkg::ld_ops_e            req_ld_ops_i,
    input  dbus_pkg::st_ops_e            req_st_ops_i,
    output logic                         credit_o,
    output logic                         head_valid_o,
    output logic [`DBUS_ADDR_WIDTH-1:0]  head_addr_o,
    output logic [`DBUS_DATA_WIDTH-1:0]  head_wdata_o,
    output dbus_pkg::ld_ops_e            head_ld_ops_o,
    output dbus_pkg::st_ops_e            head_st_ops_o
);

    localparam int DEPTH = `DBUS_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`DBUS_ADDR_WIDTH-1:0] addr_mem  [DEPTH];
    logic [`DBUS_DATA_WIDTH-1:0] wdata_mem [DEPTH];
    dbus_pkg::ld_ops_e           ld_mem    [DEPTH];
    dbus_pkg::st_ops_e           st_mem    [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push         = req_valid_i;
    assign head_valid_o = (count != '0);
    assign pop          = head_valid_o;   // Targets never stall

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop)  rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_o <= pop;   // One credit back per entry popped
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr]  <= req_addr_i;
            wdata_mem[wr_ptr] <= req_wdata_i;
            ld_mem[wr_ptr]    <= req_ld_ops_i;
            st_mem[wr_ptr]    <= req_st_ops_i;
        end
    end

    assign head_addr_o   = addr_mem[rd_ptr];
    assign head_wdata_o  = wdata_mem[rd_ptr];
    assign head_ld_ops_o = ld_mem[rd_ptr];
    assign head_st_ops_o = st_mem[rd_ptr];

    // Core must hold a credit to push
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        push |-> (count != CNT_W'(DEPTH))
    );

endmodule : dbus_req_fifo

// File: common/dbus_pkg.sv
// ------------------------------
// Data bus shared types
//   ld_ops_e    load kinds
//   st_ops_e    store kinds
//   dbus_addr_u two views of one
//               bus address
// ------------------------------

package dbus_pkg;

    typedef enum logic [2:0] {
        LD_OPS_NONE = 3'b000,
        LD_OPS_LB   = 3'b001,
        LD_OPS_LBU  = 3'b010,
        LD_OPS_LH   = 3'b011,
        LD_OPS_LHU  = 3'b100,
        LD_OPS_LW   = 3'b101
    } ld_ops_e;

    typedef enum logic [1:0] {
        ST_OPS_NONE = 2'b00,
        ST_OPS_SB   = 2'b01,
        ST_OPS_SH   = 2'b10,
        ST_OPS_SW   = 2'b11
    } st_ops_e;

    // Memory view, 1 KB region
    typedef struct packed {
        logic [21:0] region;
        logic [7:0]  word_idx;
        logic [1:0]  byte_off;
    } dmem_addr_s;

    // Peripheral view, 4 KB page
    typedef struct packed {
        logic [19:0] sel;
        logic [9:0]  reg_idx;
        logic [1:0]  byte_off;
    } peri_addr_s;

    typedef union packed {
        dmem_addr_s mem;
        peri_addr_s peri;
    } dbus_addr_u;

endpackage : dbus_pkg

// File: common/dbus_params.svh
// ------------------------------
// Data bus parameters
//   bus widths
//   address map for DMEM and GPIO
//   GPIO register indices
//   request buffer depth
// ------------------------------

`ifndef DBUS_PARAMS_SVH
`define DBUS_PARAMS_SVH

`define DBUS_ADDR_WIDTH     32
`define DBUS_DATA_WIDTH     32

// Data memory at 0x0000_0000 .. 0x0000_03FF
`define DMEM_REGION_MATCH   22'h0
`define DMEM_WORDS          256

// GPIO page at 0x8000_0000
`define GPIO_SEL_MATCH      20'h80000
`define GPIO_REG_OUT        10'd0
`define GPIO_REG_DIR        10'd1
`define GPIO_REG_IN         10'd2

// Also the initial credit count of the core
`define DBUS_FIFO_DEPTH     4

`endif
